/* verilog/displayPkg.sv */
// Display package holding the shared widths, vector types and scan constants.
`default_nettype none

package displayPkg;

  localparam int NumDigits   = 4;  // digit positions on the display.
  localparam int NumPages    = 4;  // writable display pages.
  localparam int ScanDivBits = 4;  // each digit is held for 2**ScanDivBits cycles.

  localparam int NibbleBits   = 4;
  localparam int SegmentBits  = 7;
  localparam int NumHexValues = 1 << NibbleBits;

  typedef logic [NibbleBits-1:0]              nibbleT;
  typedef logic [1:0]                         digitSelT;
  typedef logic [1:0]                         pageSelT;
  typedef logic [NumDigits*NibbleBits-1:0]    displayWordT;  // digit 0 sits in the low nibble.
  typedef logic [SegmentBits-1:0]             segmentsT;     // cathodes a..g from the msb down.
  typedef logic [NumDigits-1:0]               anodesT;       // bit n enables digit n.
  typedef logic [ScanDivBits-1:0]             prescaleT;

  // Last count of the prescaler and the last digit of a frame.
  localparam prescaleT LastPrescale = '1;
  localparam digitSelT LastDigit    = digitSelT'(NumDigits - 1);

  // Dark display levels, everything is active low.
  localparam segmentsT SegmentsBlank = '1;
  localparam anodesT   AnodesOff     = '1;

endpackage

`default_nettype wire

/* verilog/scanTimer.sv */
// Scan timer that steps the active digit and marks the start of each frame.
`timescale 1ns/1ps
`default_nettype none

module scanTimer
  import displayPkg::*;
(
  input  logic     Clk,
  input  logic     reset,
  output digitSelT digit,
  output logic     frameStart
);

  prescaleT prescale;

  always_ff @(posedge Clk) begin
    if (reset) begin
      prescale <= '0;
      digit    <= '0;
    end else begin
      prescale <= prescale + prescaleT'(1);  // wraps every 2**ScanDivBits cycles.
      if (prescale == LastPrescale) begin
        digit <= digit + digitSelT'(1);  // 3 rolls over to 0.
      end
    end
  end

  // The last cycle of digit 3 ends the frame, so the next edge starts a new one.
  assign frameStart = (prescale == LastPrescale) && (digit == LastDigit);

  // A frame is many cycles long, so the pulse can never stretch.
  frameStartSingle: assert property (
    @(posedge Clk) disable iff (reset)
    frameStart |=> !frameStart
  );

  digitStepsOnWrap: assert property (
    @(posedge Clk) disable iff (reset)
    (digit != $past(digit)) |-> ($past(prescale) == LastPrescale)
  );

endmodule

`default_nettype wire

/* verilog/pageMemory.sv */
// Page memory with four host-writable pages and a frame-synchronous shown word.
`timescale 1ns/1ps
`default_nettype none

module pageMemory
  import displayPkg::*;
(
  input  logic        Clk,
  input  logic        reset,
  input  logic        wrEn,
  input  pageSelT     wrPage,
  input  displayWordT wrData,
  input  pageSelT     showPage,
  input  logic        frameStart,
  output displayWordT shownWord
);

  displayWordT pages [NumPages];

  // Host writes land on the edge where the strobe is high.
  always_ff @(posedge Clk) begin
    if (reset) begin
      for (int p = 0; p < NumPages; p++) begin
        pages[p] <= '0;
      end
    end else if (wrEn) begin
      pages[wrPage] <= wrData;
    end
  end

  // The shown word only moves at the frame boundary so a scan never tears.
  always_ff @(posedge Clk) begin
    if (reset) begin
      shownWord <= '0;
    end else if (frameStart) begin
      shownWord <= pages[showPage];  // a write on this same edge is not seen yet.
    end
  end

  shownWordHeld: assert property (
    @(posedge Clk) disable iff (reset)
    !$past(frameStart) |-> $stable(shownWord)
  );

endmodule

`default_nettype wire

/* verilog/segmentDriver.sv */
// Segment driver that decodes the active nibble and registers the anode and cathode lines.
`timescale 1ns/1ps
`default_nettype none

module segmentDriver
  import displayPkg::*;
(
  input  logic        Clk,
  input  logic        reset,
  input  digitSelT    digit,
  input  displayWordT shownWord,
  input  logic        leadBlank,
  output anodesT      anodes,
  output segmentsT    segments,
  output logic        dp
);

  nibbleT               nibbles [NumDigits];
  logic [NumDigits-1:0] upperZero;  // bit n set when nibbles n..3 are all zero.
  nibbleT               nibble;
  logic                 blankDigit;

  // Active-low hex patterns, a in the msb and g in the lsb.
  function automatic segmentsT hexToSegments(input nibbleT value);
    case (value)
      4'h0:    return 7'b0000001;
      4'h1:    return 7'b1001111;
      4'h2:    return 7'b0010010;
      4'h3:    return 7'b0000110;
      4'h4:    return 7'b1001100;
      4'h5:    return 7'b0100100;
      4'h6:    return 7'b0100000;
      4'h7:    return 7'b0001111;
      4'h8:    return 7'b0000000;
      4'h9:    return 7'b0000100;
      4'hA:    return 7'b0001000;
      4'hB:    return 7'b1100000;
      4'hC:    return 7'b0110001;
      4'hD:    return 7'b1000010;
      4'hE:    return 7'b0110000;
      default: return 7'b0111000;
    endcase
  endfunction

  function automatic logic isHexPattern(input segmentsT pattern);
    logic found;
    found = 1'b0;
    for (int v = 0; v < NumHexValues; v++) begin
      if (hexToSegments(nibbleT'(v)) == pattern) begin
        found = 1'b1;
      end
    end
    return found;
  endfunction

  always_comb begin
    for (int i = 0; i < NumDigits; i++) begin
      nibbles[i] = shownWord[i*NibbleBits +: NibbleBits];
    end
    // Zero runs are tracked from the top digit downwards.
    upperZero[NumDigits-1] = (nibbles[NumDigits-1] == '0);
    for (int i = NumDigits - 2; i >= 0; i--) begin
      upperZero[i] = (nibbles[i] == '0) && upperZero[i+1];
    end
  end

  assign nibble     = nibbles[digit];
  assign blankDigit = leadBlank && (digit != '0) && upperZero[digit];  // digit 0 always shows.

  always_ff @(posedge Clk) begin
    if (reset) begin
      anodes   <= AnodesOff;
      segments <= SegmentsBlank;
      dp       <= 1'b1;
    end else begin
      anodes   <= ~(anodesT'(1) << digit);  // one low anode at a time.
      segments <= blankDigit ? SegmentsBlank : hexToSegments(nibble);
      dp       <= 1'b1;  // the decimal point is never lit.
    end
  end

  // The first cycle after reset is still dark, so the check starts one cycle later.
  oneAnodeActive: assert property (
    @(posedge Clk) disable iff (reset)
    !$past(reset) |-> $onehot(~anodes)
  );

  dpDark: assert property (
    @(posedge Clk) disable iff (reset)
    dp
  );

  segmentsLegal: assert property (
    @(posedge Clk) disable iff (reset)
    (segments == SegmentsBlank) || isHexPattern(segments)
  );

endmodule

`default_nettype wire

/* verilog/displayTop.sv */
// Display top that ties the scan timer and page memory to the segment driver.
`timescale 1ns/1ps
`default_nettype none

module displayTop
  import displayPkg::*;
(
  input  logic        Clk,
  input  logic        reset,
  input  logic        wrEn,
  input  pageSelT     wrPage,
  input  displayWordT wrData,
  input  pageSelT     showPage,
  input  logic        leadBlank,
  output anodesT      anodes,
  output segmentsT    segments,
  output logic        dp
);

  digitSelT    digit;
  logic        frameStart;  // one cycle per 64-cycle frame.
  displayWordT shownWord;

  scanTimer i_scanTimer (
    .Clk        (Clk),
    .reset      (reset),
    .digit      (digit),
    .frameStart (frameStart)
  );

  // Loads the shown word on the same edge that takes digit back to 0.
  pageMemory i_pageMemory (
    .Clk        (Clk),
    .reset      (reset),
    .wrEn       (wrEn),
    .wrPage     (wrPage),
    .wrData     (wrData),
    .showPage   (showPage),
    .frameStart (frameStart),
    .shownWord  (shownWord)
  );

  segmentDriver i_segmentDriver (
    .Clk       (Clk),
    .reset     (reset),
    .digit     (digit),
    .shownWord (shownWord),
    .leadBlank (leadBlank),
    .anodes    (anodes),
    .segments  (segments),
    .dp        (dp)
  );

endmodule

`default_nettype wire

/* test/displayTb.sv */
// Testbench for the display top, checking its scan, decode, paging and blanking against a model.
`timescale 1ns/1ps
`default_nettype none

module displayTb
  import displayPkg::*;
();

  localparam int FrameCycles = NumDigits * (1 << ScanDivBits);
  localparam int RandomFrames = 24;
  localparam int MaxCycles = 4000;  // about 50 frames of tests plus a margin.

  logic        Clk = 1'b0;
  logic        reset;
  logic        wrEn;
  pageSelT     wrPage;
  displayWordT wrData;
  pageSelT     showPage;
  logic        leadBlank;
  anodesT      anodes;
  segmentsT    segments;
  logic        dp;

  // Reference model state, updated on every rising edge.
  displayWordT modelPages [NumPages];
  displayWordT modelShown;
  prescaleT    modelPrescale;
  digitSelT    modelDigit;
  anodesT      expAnodes;
  segmentsT    expSegments;
  logic        expDp;
  logic        modelValid = 1'b0;

  string  testName;
  int     errorCount = 0;
  int     checkCount = 0;
  int     cycleCount = 0;
  int     shiftNibbles;
  integer seed = 32'h195d58f7;

  displayTop i_dut (
    .Clk       (Clk),
    .reset     (reset),
    .wrEn      (wrEn),
    .wrPage    (wrPage),
    .wrData    (wrData),
    .showPage  (showPage),
    .leadBlank (leadBlank),
    .anodes    (anodes),
    .segments  (segments),
    .dp        (dp)
  );

  always #20 Clk = ~Clk;  // 40 ns period.

  // Active-low glyphs with segment a in bit 6 and g in bit 0.
  function automatic segmentsT hexGlyph(input nibbleT value);
    case (value)
      4'h0:    return 7'b0000001;
      4'h1:    return 7'b1001111;
      4'h2:    return 7'b0010010;
      4'h3:    return 7'b0000110;
      4'h4:    return 7'b1001100;
      4'h5:    return 7'b0100100;
      4'h6:    return 7'b0100000;
      4'h7:    return 7'b0001111;
      4'h8:    return 7'b0000000;
      4'h9:    return 7'b0000100;
      4'hA:    return 7'b0001000;
      4'hB:    return 7'b1100000;
      4'hC:    return 7'b0110001;
      4'hD:    return 7'b1000010;
      4'hE:    return 7'b0110000;
      default: return 7'b0111000;
    endcase
  endfunction

  // Returns the expected anodes in the upper 4 bits and the segments below them.
  function automatic logic [10:0] expectedOutputs(input digitSelT d, input displayWordT w,
                                                  input logic blank);
    anodesT      a;
    segmentsT    s;
    displayWordT upper;
    a = 4'b1111;
    a[d] = 1'b0;
    upper = w >> (4 * d);  // the shown nibble and everything above it.
    if (blank && (d != 2'd0) && (upper == 16'h0)) begin
      s = 7'h7F;
    end else begin
      s = hexGlyph(w[4*d +: 4]);
    end
    return {a, s};
  endfunction

  always @(posedge Clk) begin : refModel
    logic [10:0] expected;
    if (reset) begin
      for (int p = 0; p < NumPages; p++) begin
        modelPages[p] = 16'h0;
      end
      modelShown    = 16'h0;
      modelPrescale = 4'h0;
      modelDigit    = 2'd0;
      expAnodes     = 4'hF;
      expSegments   = 7'h7F;
      expDp         = 1'b1;
    end else begin
      expected    = expectedOutputs(modelDigit, modelShown, leadBlank);
      expAnodes   = expected[10:7];
      expSegments = expected[6:0];
      expDp       = 1'b1;
      if ((modelPrescale == 4'hF) && (modelDigit == 2'd3)) begin
        modelShown = modelPages[showPage];  // loaded before a write on the same edge.
      end
      if (wrEn) begin
        modelPages[wrPage] = wrData;
      end
      if (modelPrescale == 4'hF) begin
        modelDigit = modelDigit + 2'd1;
      end
      modelPrescale = modelPrescale + 4'd1;
    end
    modelValid = 1'b1;
  end

  // Outputs are compared half a cycle after each rising edge, where they are stable.
  always @(negedge Clk) begin
    if (modelValid) begin
      checkCount++;
      if (anodes !== expAnodes) begin
        errorCount++;
        $display("[ERROR] %s: anodes expected %b, actual %b", testName, expAnodes, anodes);
      end
      if (segments !== expSegments) begin
        errorCount++;
        $display("[ERROR] %s: segments expected %b, actual %b", testName, expSegments, segments);
      end
      if (dp !== expDp) begin
        errorCount++;
        $display("[ERROR] %s: dp expected %b, actual %b", testName, expDp, dp);
      end
    end
  end

  always @(posedge Clk) begin
    cycleCount++;
    if (cycleCount >= MaxCycles) begin
      $display("Timeout: the tests did not finish within %0d cycles.", MaxCycles);
      $display("Checks: %0d, errors: %0d", checkCount, errorCount);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic checkField(input string name, input logic [15:0] expected,
                            input logic [15:0] actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // Returns at the falling edge of the last cycle of a frame.
  task automatic waitFrameStart();
    @(negedge Clk);
    while (!((modelPrescale == LastPrescale) && (modelDigit == LastDigit))) begin
      @(negedge Clk);
    end
  endtask

  // Writes a word, selects its page and keeps it on the display for one full frame.
  task automatic showWord(input pageSelT page, input displayWordT word, input logic blank);
    @(negedge Clk);
    wrEn      = 1'b1;
    wrPage    = page;
    wrData    = word;
    showPage  = page;
    leadBlank = blank;
    @(negedge Clk);
    wrEn = 1'b0;
    waitFrameStart();
    waitFrameStart();
  endtask

  initial begin
    reset     = 1'b1;
    wrEn      = 1'b0;
    wrPage    = 2'd0;
    wrData    = 16'h0;
    showPage  = 2'd0;
    leadBlank = 1'b0;
    testName  = "reset";
    repeat (4) @(posedge Clk);
    @(negedge Clk);
    checkField("reset anodes", 16'(AnodesOff), 16'(anodes));
    checkField("reset segments", 16'(SegmentsBlank), 16'(segments));
    reset = 1'b0;
    checkField("release anodes", 16'(AnodesOff), 16'(anodes));  // still dark here.
    checkField("release dp", 16'h1, 16'(dp));

    testName = "scan";
    waitFrameStart();
    waitFrameStart();

    testName = "hex";
    showWord(2'd2, 16'h3210, 1'b0);
    showWord(2'd2, 16'h7654, 1'b0);
    showWord(2'd2, 16'hBA98, 1'b0);
    showWord(2'd2, 16'hFEDC, 1'b0);

    testName = "boundary";
    showWord(2'd0, 16'h1234, 1'b0);
    repeat (FrameCycles / 2) @(negedge Clk);
    wrEn     = 1'b1;
    wrPage   = 2'd1;
    wrData   = 16'hCAFE;
    showPage = 2'd1;
    @(negedge Clk);
    wrPage = 2'd0;  // the page that is on the display right now.
    wrData = 16'hBEEF;
    @(negedge Clk);
    wrEn = 1'b0;
    waitFrameStart();
    wrEn   = 1'b1;  // same edge as the load, so the new frame keeps the older word.
    wrPage = 2'd1;
    wrData = 16'h5555;
    @(negedge Clk);
    wrEn = 1'b0;
    @(negedge Clk);
    checkField("boundary anodes", 16'h000E, 16'(anodes));
    checkField("boundary segments", 16'(hexGlyph(4'hE)), 16'(segments));
    waitFrameStart();
    waitFrameStart();

    testName = "blank";
    showWord(2'd0, 16'h0000, 1'b1);
    showWord(2'd1, 16'h0005, 1'b1);
    showWord(2'd2, 16'h00A0, 1'b1);
    showWord(2'd3, 16'h1000, 1'b1);
    showWord(2'd1, 16'h0005, 1'b0);
    showWord(2'd2, 16'h00A0, 1'b0);

    testName = "random";
    repeat (RandomFrames * FrameCycles) begin
      @(negedge Clk);
      wrEn         = (($random(seed) & 3) == 0);
      wrPage       = pageSelT'($random(seed));
      shiftNibbles = $random(seed) & 3;
      wrData       = displayWordT'($random(seed)) >> (4 * shiftNibbles);  // favours zeros on top.
      if (($random(seed) & 63) == 0) begin
        showPage = pageSelT'($random(seed));
      end
      if (($random(seed) & 127) == 0) begin
        leadBlank = ~leadBlank;
      end
    end
    wrEn = 1'b0;

    @(posedge Clk);
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
verilog/displayPkg.sv
verilog/scanTimer.sv
verilog/pageMemory.sv
verilog/segmentDriver.sv
verilog/displayTop.sv
test/displayTb.sv

/* Makefile */
# Builds the display testbench with Verilator and runs it.

VERILATOR ?= verilator
FILELIST  ?= sim.f
TOP       ?= displayTb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

# Sources are taken from the file list so the binary follows every edit.
SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST) Makefile
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The run fails when the log holds the fail message or lacks the pass message.
run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then \
	  echo "Simulation reported a failure, see $(LOG)."; \
	  exit 1; \
	fi
	@if ! grep -qF '*** TEST PASSED ***' $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)."; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
